/* ramp_params.svh */
// Default sizes only; RAMP_CHANNEL_BITS must address RAMP_N_CHANNELS and no width may exceed 32
`ifndef RAMP_PARAMS_SVH
`define RAMP_PARAMS_SVH

// Number of independent ramp channels
`define RAMP_N_CHANNELS 4

// Width of a ramp value, stop value and step increment
`define RAMP_VALUE_WIDTH 16

// Width of the stream dest tag carried with every sample
`define RAMP_DEST_WIDTH 8

// Width of the timebase divisor and of each channel's tick counter
`define RAMP_DIVISOR_WIDTH 16

// Address bits above the register offset that select a channel
`define RAMP_CHANNEL_BITS 2

`endif

/* ramp_pkg.sv */
// Types follow the widths in ramp_params.svh; the register offset is always two bits
`include "ramp_params.svh"

package ramp_pkg;

    // One ramp value, also used for the stop value and the increment
    typedef logic [`RAMP_VALUE_WIDTH-1:0] ramp_value_t;

    // Destination tag attached to each output sample
    typedef logic [`RAMP_DEST_WIDTH-1:0] ramp_dest_t;

    // Timebase divisor, a tick every divisor clocks
    typedef logic [`RAMP_DIVISOR_WIDTH-1:0] ramp_divisor_t;

    // Register offsets inside one channel's block of four
    // A write to the stop offset is what starts a ramp
    typedef enum logic [1:0] {
        ramp_reg_stop      = 2'd0,
        ramp_reg_dest      = 2'd1,
        ramp_reg_increment = 2'd2,
        ramp_reg_divisor   = 2'd3
    } ramp_reg_e;

endpackage

/* ramp_register_file.sv */
// Writes to channels beyond RAMP_N_CHANNELS are dropped and read as zero; write data is truncated
`include "ramp_params.svh"

module ramp_register_file (
    input  logic                                            clock,
    input  logic                                            reset,
    input  logic                                            reg_write,
    input  logic [`RAMP_CHANNEL_BITS+1:0]                   reg_address,
    input  logic [31:0]                                     reg_write_data,
    input  logic [`RAMP_CHANNEL_BITS+1:0]                   reg_read_address,
    output logic [31:0]                                     reg_read_data,
    output ramp_pkg::ramp_value_t   [`RAMP_N_CHANNELS-1:0] stop_value,
    output ramp_pkg::ramp_dest_t    [`RAMP_N_CHANNELS-1:0] dest,
    output ramp_pkg::ramp_value_t   [`RAMP_N_CHANNELS-1:0] increment,
    output ramp_pkg::ramp_divisor_t [`RAMP_N_CHANNELS-1:0] divisor,
    output logic                    [`RAMP_N_CHANNELS-1:0] trigger
);
    import ramp_pkg::*;

    // The channel index sits above the two offset bits
    logic [`RAMP_CHANNEL_BITS-1:0] write_channel;
    ramp_reg_e                     write_offset;
    logic [`RAMP_CHANNEL_BITS-1:0] read_channel;
    ramp_reg_e                     read_offset;

    assign write_channel = reg_address[`RAMP_CHANNEL_BITS+1:2];
    assign write_offset  = ramp_reg_e'(reg_address[1:0]);
    assign read_channel  = reg_read_address[`RAMP_CHANNEL_BITS+1:2];
    assign read_offset   = ramp_reg_e'(reg_read_address[1:0]);

    // Register storage and the start trigger
    // The trigger is registered so that it rises together with the new stop value
    always_ff @(posedge clock) begin
        if (!reset) begin
            stop_value <= '0;
            dest       <= '0;
            increment  <= '0;
            divisor    <= '0;
            trigger    <= '0;
        end else begin
            // A trigger lasts exactly one cycle
            trigger <= '0;
            if (reg_write && (write_channel < `RAMP_N_CHANNELS)) begin
                case (write_offset)
                    ramp_reg_stop: begin
                        stop_value[write_channel] <= reg_write_data[`RAMP_VALUE_WIDTH-1:0];
                        trigger[write_channel]    <= 1'b1;
                    end
                    ramp_reg_dest: begin
                        dest[write_channel] <= reg_write_data[`RAMP_DEST_WIDTH-1:0];
                    end
                    ramp_reg_increment: begin
                        increment[write_channel] <= reg_write_data[`RAMP_VALUE_WIDTH-1:0];
                    end
                    default: begin
                        divisor[write_channel] <= reg_write_data[`RAMP_DIVISOR_WIDTH-1:0];
                    end
                endcase
            end
        end
    end

    // Read-back with one cycle of latency, every field zero-extended to the bus width
    always_ff @(posedge clock) begin
        reg_read_data <= '0;
        if (read_channel < `RAMP_N_CHANNELS) begin
            case (read_offset)
                ramp_reg_stop:      reg_read_data <= 32'(stop_value[read_channel]);
                ramp_reg_dest:      reg_read_data <= 32'(dest[read_channel]);
                ramp_reg_increment: reg_read_data <= 32'(increment[read_channel]);
                default:            reg_read_data <= 32'(divisor[read_channel]);
            endcase
        end
    end

endmodule

/* ramp_channel.sv */
// Increment must be nonzero; a step that would leave the value range lands on the stop value
`include "ramp_params.svh"

module ramp_channel (
    input  logic                    clock,
    input  logic                    reset,
    input  ramp_pkg::ramp_value_t   stop_value,
    input  ramp_pkg::ramp_dest_t    dest,
    input  ramp_pkg::ramp_value_t   increment,
    input  ramp_pkg::ramp_divisor_t divisor,
    input  logic                    trigger,
    input  logic                    slot_taken,
    output logic                    slot_valid,
    output ramp_pkg::ramp_value_t   slot_data,
    output ramp_pkg::ramp_dest_t    slot_dest
);
    import ramp_pkg::*;

    ramp_divisor_t               tb_count;
    logic                        tick;
    ramp_value_t                 last_stop;
    ramp_value_t                 shadow_stop;
    ramp_value_t                 current;
    ramp_value_t                 next_value;
    ramp_value_t                 start_from;
    logic [`RAMP_VALUE_WIDTH:0]  step_sum;
    logic                        ramp_up;
    logic                        running;
    logic                        reached;
    logic                        fill;
    logic                        start;

    // Timebase enable
    // Divisors 0 and 1 tick every cycle, otherwise the counter wraps every divisor clocks
    assign tick = (divisor < ramp_divisor_t'(2))
               || (tb_count >= divisor - ramp_divisor_t'(1));

    always_ff @(posedge clock) begin
        if (!reset) begin
            tb_count <= '0;
        end else if (tick) begin
            tb_count <= '0;
        end else begin
            tb_count <= tb_count + ramp_divisor_t'(1);
        end
    end

    // The ramp ends once the running value meets or passes the stop value
    assign reached = ramp_up ? (current >= shadow_stop) : (current <= shadow_stop);

    // Step with one spare bit, which flags a carry going up or a borrow going down
    assign step_sum = ramp_up ? ({1'b0, current} + {1'b0, increment})
                              : ({1'b0, current} - {1'b0, increment});

    // Clamping to the stop value makes the next fill emit the stop value and end the ramp
    assign next_value = step_sum[`RAMP_VALUE_WIDTH] ? shadow_stop
                                                    : step_sum[`RAMP_VALUE_WIDTH-1:0];

    // The slot fills on a tick while running, if it is empty or being drained this cycle
    // A tick that finds the slot full is simply lost, the value waits for the next one
    assign fill = tick && running && !(slot_valid && !slot_taken);

    // A ramp finishing in this same cycle already counts as completed for a new trigger
    assign start_from = (fill && reached) ? shadow_stop : last_stop;

    // Rewriting the last completed stop value does nothing
    assign start = trigger && (stop_value != start_from);

    // Control state
    always_ff @(posedge clock) begin
        if (!reset) begin
            running    <= 1'b0;
            last_stop  <= '0;
            slot_valid <= 1'b0;
        end else begin
            if (slot_taken) begin
                slot_valid <= 1'b0;
            end
            if (fill) begin
                slot_valid <= 1'b1;
                if (reached) begin
                    running   <= 1'b0;
                    last_stop <= shadow_stop;
                end
            end
            // A new trigger restarts even a ramp that is still running
            if (start) begin
                running <= 1'b1;
            end
        end
    end

    // Ramp datapath and slot payload
    always_ff @(posedge clock) begin
        if (fill) begin
            slot_data <= reached ? shadow_stop : current;
            slot_dest <= dest;
            if (!reached) begin
                current <= next_value;
            end
        end
        // The trigger wins over the step so the new ramp starts clean
        if (start) begin
            shadow_stop <= stop_value;
            ramp_up     <= start_from < stop_value;
            current     <= start_from;
        end
    end

endmodule

/* ramp_stream_merger.sv */
// One sample per cycle at most; output payload is undefined until the first transfer
`include "ramp_params.svh"

module ramp_stream_merger (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                  [`RAMP_N_CHANNELS-1:0] slot_valid,
    input  ramp_pkg::ramp_value_t [`RAMP_N_CHANNELS-1:0] slot_data,
    input  ramp_pkg::ramp_dest_t  [`RAMP_N_CHANNELS-1:0] slot_dest,
    output logic                  [`RAMP_N_CHANNELS-1:0] slot_taken,
    output logic                                          out_valid,
    output ramp_pkg::ramp_value_t                         out_data,
    output ramp_pkg::ramp_dest_t                          out_dest,
    input  logic                                          out_ready
);
    import ramp_pkg::*;

    localparam int n_channels = `RAMP_N_CHANNELS;

    logic [`RAMP_CHANNEL_BITS-1:0] last_served;
    logic [`RAMP_CHANNEL_BITS-1:0] pick;
    logic                          pick_found;
    logic                          take;

    // Round-robin search starting just after the channel served last
    // Walking the offsets downward lets the nearest valid slot overwrite the farther ones
    always_comb begin
        int candidate;
        pick       = last_served;
        pick_found = 1'b0;
        for (int k = n_channels; k >= 1; k--) begin
            candidate = (int'(last_served) + k) % n_channels;
            if (slot_valid[candidate]) begin
                pick       = candidate[`RAMP_CHANNEL_BITS-1:0];
                pick_found = 1'b1;
            end
        end
    end

    // The output register accepts a new sample when empty or when it transfers now
    assign take = pick_found && (!out_valid || out_ready);

    always_comb begin
        slot_taken       = '0;
        slot_taken[pick] = take;
    end

    // Output valid and the round-robin pointer
    // The pointer starts on the last channel so channel 0 has first turn
    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid   <= 1'b0;
            last_served <= (`RAMP_CHANNEL_BITS)'(n_channels - 1);
        end else if (take) begin
            out_valid   <= 1'b1;
            last_served <= pick;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Data and dest only change on a take, so they hold under back-pressure
    always_ff @(posedge clock) begin
        if (take) begin
            out_data <= slot_data[pick];
            out_dest <= slot_dest[pick];
        end
    end

endmodule

/* ramp_generator_top.sv */
// Register port has no flow control; the output stream follows valid/ready with held payload
`include "ramp_params.svh"

module ramp_generator_top (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          reg_write,
    input  logic [`RAMP_CHANNEL_BITS+1:0] reg_address,
    input  logic [31:0]                   reg_write_data,
    input  logic [`RAMP_CHANNEL_BITS+1:0] reg_read_address,
    output logic [31:0]                   reg_read_data,
    output logic                          out_valid,
    output ramp_pkg::ramp_value_t         out_data,
    output ramp_pkg::ramp_dest_t          out_dest,
    input  logic                          out_ready
);
    import ramp_pkg::*;

    // Per-channel register values from the register file
    ramp_value_t   [`RAMP_N_CHANNELS-1:0] stop_value;
    ramp_dest_t    [`RAMP_N_CHANNELS-1:0] dest;
    ramp_value_t   [`RAMP_N_CHANNELS-1:0] increment;
    ramp_divisor_t [`RAMP_N_CHANNELS-1:0] divisor;
    logic          [`RAMP_N_CHANNELS-1:0] trigger;

    // Channel slots toward the merger, and the drain pulses back
    logic          [`RAMP_N_CHANNELS-1:0] slot_valid;
    ramp_value_t   [`RAMP_N_CHANNELS-1:0] slot_data;
    ramp_dest_t    [`RAMP_N_CHANNELS-1:0] slot_dest;
    logic          [`RAMP_N_CHANNELS-1:0] slot_taken;

    ramp_register_file u_register_file (
        .clock            (clock),
        .reset            (reset),
        .reg_write        (reg_write),
        .reg_address      (reg_address),
        .reg_write_data   (reg_write_data),
        .reg_read_address (reg_read_address),
        .reg_read_data    (reg_read_data),
        .stop_value       (stop_value),
        .dest             (dest),
        .increment        (increment),
        .divisor          (divisor),
        .trigger          (trigger)
    );

    // One ramp engine per channel, each with its own timebase
    for (genvar i = 0; i < `RAMP_N_CHANNELS; i++) begin : g_channel
        ramp_channel u_channel (
            .clock      (clock),
            .reset      (reset),
            .stop_value (stop_value[i]),
            .dest       (dest[i]),
            .increment  (increment[i]),
            .divisor    (divisor[i]),
            .trigger    (trigger[i]),
            .slot_taken (slot_taken[i]),
            .slot_valid (slot_valid[i]),
            .slot_data  (slot_data[i]),
            .slot_dest  (slot_dest[i])
        );
    end

    ramp_stream_merger u_merger (
        .clock      (clock),
        .reset      (reset),
        .slot_valid (slot_valid),
        .slot_data  (slot_data),
        .slot_dest  (slot_dest),
        .slot_taken (slot_taken),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_dest   (out_dest),
        .out_ready  (out_ready)
    );

endmodule

/* tb_ramp_generator.sv */
// Assumes the default sizes in ramp_params.svh, four channels and 16-bit values
`include "ramp_params.svh"

module tb_ramp_generator;
    import ramp_pkg::*;

    localparam int timeout_cycles = 20000;
    localparam int n_channels = `RAMP_N_CHANNELS;
    localparam int address_width = `RAMP_CHANNEL_BITS + 2;

    logic                     clock;
    logic                     reset;
    logic                     reg_write;
    logic [address_width-1:0] reg_address;
    logic [31:0]              reg_write_data;
    logic [address_width-1:0] reg_read_address;
    logic [31:0]              reg_read_data;
    logic                     out_valid;
    ramp_value_t              out_data;
    ramp_dest_t               out_dest;
    logic                     out_ready;

    // Every transferred sample in arrival order, with the cycle it was taken
    int sample_data[$];
    int sample_dest[$];
    int sample_cycle[$];
    int expected[$];
    // Each channel's last completed stop value as the tests track it
    int last_stop[n_channels];
    int cycle_count;
    int error_count;
    int check_count;
    string test_name;
    logic random_ready;
    logic held;
    ramp_value_t held_data;
    ramp_dest_t held_dest;

    ramp_generator_top u_dut (
        .clock            (clock),
        .reset            (reset),
        .reg_write        (reg_write),
        .reg_address      (reg_address),
        .reg_write_data   (reg_write_data),
        .reg_read_address (reg_read_address),
        .reg_read_data    (reg_read_data),
        .out_valid        (out_valid),
        .out_data         (out_data),
        .out_dest         (out_dest),
        .out_ready        (out_ready)
    );

    always #4 clock = ~clock;

    // Stream monitor, which sees the values that were present just before the edge
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        // A stalled sample must stay valid and unchanged
        if (reset && held) begin
            check_count++;
            if (!out_valid) begin
                $display("out_valid dropped while the stream was stalled, cycle %0d",
                         cycle_count);
                error_count++;
            end else if (out_data != held_data || out_dest != held_dest) begin
                $display("CHECK FAILED %s stalled payload: expected %h/%h, actual %h/%h",
                         test_name, held_data, held_dest, out_data, out_dest);
                error_count++;
            end
        end
        if (reset && out_valid && out_ready) begin
            sample_data.push_back(int'(out_data));
            sample_dest.push_back(int'(out_dest));
            sample_cycle.push_back(cycle_count);
        end
        held = reset && out_valid && !out_ready;
        held_data = out_data;
        held_dest = out_dest;
    end

    // Ready is high unless a test asks for a random back-pressure pattern
    initial begin
        void'($urandom(32'h7b4d_dc4c));
        forever begin
            @(posedge clock);
            #1;
            if (random_ready)
                out_ready = 1'($urandom & 1);
            else
                out_ready = 1'b1;
        end
    end

    task automatic write_register(input int channel, input int offset, input logic [31:0] data);
        @(posedge clock);
        #1;
        reg_write = 1'b1;
        reg_address = address_width'(channel * 4 + offset);
        reg_write_data = data;
        @(posedge clock);
        #1;
        reg_write = 1'b0;
    endtask

    task automatic read_register(input int channel, input int offset, output logic [31:0] data);
        @(posedge clock);
        #1;
        reg_read_address = address_width'(channel * 4 + offset);
        @(posedge clock);
        #1;
        data = reg_read_data;
    endtask

    task automatic clear_samples();
        sample_data.delete();
        sample_dest.delete();
        sample_cycle.delete();
    endtask

    // Waits until the stream has been idle long enough for any ramp to have ended
    task automatic drain_stream();
        int quiet;
        quiet = 0;
        while (quiet < 40) begin
            @(negedge clock);
            if (out_valid)
                quiet = 0;
            else
                quiet++;
        end
    endtask

    function automatic int count_dest(input int dest);
        int n;
        n = 0;
        foreach (sample_dest[i])
            if (sample_dest[i] == dest)
                n++;
        return n;
    endfunction

    // Start value, then every step strictly short of the stop value, then the stop value
    function automatic void build_model(input int start, input int stop, input int step);
        int value;
        logic done;
        expected.delete();
        value = start;
        done = (start == stop);
        if (!done)
            expected.push_back(start);
        while (!done) begin
            value = (stop > start) ? value + step : value - step;
            if ((stop > start) ? (value < stop) : (value > stop)) begin
                expected.push_back(value);
            end else begin
                expected.push_back(stop);
                done = 1'b1;
            end
        end
    endfunction

    // Waits for one channel's ramp and compares its samples, in order, with the model
    task automatic check_ramp(input string name, input int channel, input int dest,
                              input int stop, input int step, input int min_gap);
        int position;
        int previous_cycle;
        build_model(last_stop[channel], stop, step);
        while (count_dest(dest) < expected.size())
            @(negedge clock);
        drain_stream();
        last_stop[channel] = stop;
        check_count++;
        if (count_dest(dest) != expected.size()) begin
            $display("CHECK FAILED %s dest %0d count: expected %0d, actual %0d",
                     name, dest, expected.size(), count_dest(dest));
            error_count++;
        end
        position = 0;
        previous_cycle = 0;
        foreach (sample_dest[i]) begin
            if (sample_dest[i] == dest && position < expected.size()) begin
                check_count++;
                if (sample_data[i] != expected[position]) begin
                    $display("CHECK FAILED %s dest %0d sample %0d: expected %0d, actual %0d",
                             name, dest, position, expected[position], sample_data[i]);
                    error_count++;
                end
                if (position > 0 && sample_cycle[i] - previous_cycle < min_gap) begin
                    $display("CHECK FAILED %s sample gap: expected >= %0d, actual %0d",
                             name, min_gap, sample_cycle[i] - previous_cycle);
                    error_count++;
                end
                previous_cycle = sample_cycle[i];
                position++;
            end
        end
    endtask

    // Register contents for the readback test, all sixteen distinct
    function automatic logic [15:0] field_value(input int channel, input int offset);
        case (offset)
            0: return 16'h1200 + 16'(channel * 16'h11);
            1: return 16'h3cc0 + 16'(channel);
            2: return 16'h0400 + 16'(channel);
            default: return 16'h0002 + 16'(channel);
        endcase
    endfunction

    function automatic logic [31:0] field_mask(input int offset);
        case (offset)
            1: return (32'd1 << `RAMP_DEST_WIDTH) - 1;
            3: return (32'd1 << `RAMP_DIVISOR_WIDTH) - 1;
            default: return (32'd1 << `RAMP_VALUE_WIDTH) - 1;
        endcase
    endfunction

    task automatic register_readback();
        logic [31:0] value;
        logic [31:0] want;
        int offset;
        test_name = "readback";
        clear_samples();
        // Stop goes last, so each ramp it starts already has its increment and divisor
        for (int ch = 0; ch < n_channels; ch++) begin
            for (int k = 1; k <= 4; k++) begin
                offset = k % 4;
                write_register(ch, offset, 32'h5a5a_0000 | 32'(field_value(ch, offset)));
            end
        end
        for (int ch = 0; ch < n_channels; ch++) begin
            for (int off = 0; off < 4; off++) begin
                read_register(ch, off, value);
                want = 32'(field_value(ch, off)) & field_mask(off);
                check_count++;
                if (value != want) begin
                    $display("CHECK FAILED readback ch %0d offset %0d: expected %h, actual %h",
                             ch, off, want, value);
                    error_count++;
                end
            end
        end
        // The written stop values started ramps, which are checked and then undone
        for (int ch = 0; ch < n_channels; ch++)
            check_ramp("readback ramp", ch, int'(field_value(ch, 1) & field_mask(1)),
                       int'(field_value(ch, 0)), int'(field_value(ch, 2)), 0);
        clear_samples();
        for (int ch = 0; ch < n_channels; ch++)
            write_register(ch, 0, 32'h0);
        for (int ch = 0; ch < n_channels; ch++)
            check_ramp("return ramp", ch, int'(field_value(ch, 1) & field_mask(1)), 0,
                       int'(field_value(ch, 2)), 0);
    endtask

    task automatic upward_ramp();
        test_name = "upward";
        clear_samples();
        write_register(0, 3, 32'd1);
        write_register(0, 2, 32'd7);
        write_register(0, 1, 32'h10);
        write_register(0, 0, 32'd50);
        check_ramp("upward", 0, 'h10, 50, 7, 0);
    endtask

    task automatic downward_ramp();
        test_name = "downward";
        clear_samples();
        write_register(1, 3, 32'd1);
        write_register(1, 2, 32'd10);
        write_register(1, 1, 32'h21);
        write_register(1, 0, 32'd40);
        check_ramp("downward setup", 1, 'h21, 40, 10, 0);
        clear_samples();
        write_register(1, 3, 32'd5);
        write_register(1, 2, 32'd6);
        write_register(1, 0, 32'd3);
        check_ramp("downward", 1, 'h21, 3, 6, 5);
    endtask

    // All channels at once, each with its own dest, increment and divisor
    task automatic run_concurrent(input string name, input logic random_enable,
                                  input int stop0, input int stop1, input int stop2,
                                  input int stop3);
        int stops[n_channels];
        int steps[n_channels];
        int divisors[n_channels];
        test_name = name;
        stops = '{stop0, stop1, stop2, stop3};
        steps = '{23, 17, 11, 9};
        divisors = '{1, 2, 1, 3};
        clear_samples();
        for (int ch = 0; ch < n_channels; ch++) begin
            write_register(ch, 1, 32'(8'h30 + ch));
            write_register(ch, 2, 32'(steps[ch]));
            write_register(ch, 3, 32'(divisors[ch]));
        end
        @(negedge clock);
        random_ready = random_enable;
        for (int ch = 0; ch < n_channels; ch++)
            write_register(ch, 0, 32'(stops[ch]));
        for (int ch = 0; ch < n_channels; ch++)
            check_ramp(name, ch, 'h30 + ch, stops[ch], steps[ch], 0);
        @(negedge clock);
        random_ready = 1'b0;
    endtask

    task automatic noop_trigger();
        test_name = "noop trigger";
        clear_samples();
        write_register(2, 0, 32'(last_stop[2]));
        // A ramp started here would have produced its first sample well within this window
        repeat (200) @(negedge clock);
        check_count++;
        if (sample_data.size() != 0) begin
            $display("CHECK FAILED noop trigger: expected 0 samples, actual %0d",
                     sample_data.size());
            error_count++;
        end
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        reg_write = 1'b0;
        reg_address = '0;
        reg_write_data = '0;
        reg_read_address = '0;
        out_ready = 1'b1;
        random_ready = 1'b0;
        held = 1'b0;
        cycle_count = 0;
        error_count = 0;
        check_count = 0;
        test_name = "reset";
        foreach (last_stop[i])
            last_stop[i] = 0;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b1;
        register_readback();
        upward_ramp();
        downward_ramp();
        run_concurrent("concurrent", 1'b0, 300, 200, 150, 90);
        run_concurrent("back-pressure", 1'b1, 20, 260, 40, 0);
        noop_trigger();
        $display("errors: %0d, checks: %0d", error_count, check_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // The limit leaves a wide margin over the length of all tests together
    initial begin
        wait (cycle_count >= timeout_cycles);
        $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
        $display("errors: %0d, checks: %0d", error_count, check_count);
        $display("test failed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
ramp_pkg.sv
ramp_register_file.sv
ramp_channel.sv
ramp_stream_merger.sv
ramp_generator_top.sv
tb_ramp_generator.sv

/* Bender.yml */
package:
  name: ramp_generator

sources:
  - include_dirs:
      - .
    files:
      - ramp_pkg.sv
      - ramp_register_file.sv
      - ramp_channel.sv
      - ramp_stream_merger.sv
      - ramp_generator_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ramp_generator.sv
